// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LCD text testbench with Verilator.
# Exit status is nonzero if the build or the simulation fails.
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
top=tb_lcd_text

verilator --binary --timing --assert -f tb.f --top-module "$top" -Mdir "$build_dir" -o sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

"./$build_dir/sim"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

// ==== tb.f ====
verilog/lcd_pkg.sv
verilog/lcd_script_rom.sv
verilog/lcd_sequencer.sv
verilog/lcd_nibble_tx.sv
verilog/lcd_text_top.sv
verification/lcd_bus_checker.sv
verification/tb_lcd_text.sv

// ==== verification/lcd_bus_checker.sv ====
/*
 * Protocol assertions on the LCD pins of the nibble transmitter.
 * Bound into lcd_nibble_tx from the testbench.
 */
module lcd_bus_checker #(
    parameter int e_cycles = 2
) (
    input logic                 clk,
    input logic                 nrst,
    input lcd_pkg::lcd_nibble_t db,
    input logic                 rs,
    input logic                 e,
    input logic                 ack
);
    timeunit 1ns;
    timeprecision 1ps;

    int high_run;  // Cycles e has been high so far

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            high_run <= 0;
        end else if (e) begin
            high_run <= high_run + 1;
        end else begin
            high_run <= 0;
        end
    end

    // Panel latches on the falling edge, so data must not move while e is high
    a_data_stable: assert property (@(posedge clk) disable iff (!nrst)
        (e && $past(e)) |-> ($stable(db) && $stable(rs)))
        else $error("db or rs changed while e was high");

    a_pulse_width: assert property (@(posedge clk) disable iff (!nrst)
        $fell(e) |-> (high_run == e_cycles))
        else $error("enable pulse width %0d, expected %0d", high_run, e_cycles);

    a_idle_on_ack: assert property (@(posedge clk) disable iff (!nrst)
        ack |-> !e)
        else $error("e high while ack is held");

endmodule

// ==== verification/tb_lcd_text.sv ====
/*
 * Testbench for lcd_text_top with shortened timing.
 * Captures each enable pulse on the pins and checks it against the script rules.
 */
module tb_lcd_text;
    timeunit 1ns;
    timeprecision 1ps;

    import lcd_pkg::*;

    localparam int e_cycles        = 3;
    localparam int power_on_cycles = 40;
    localparam int short_cycles    = 8;
    localparam int long_cycles     = 20;
    localparam int clear_cycles    = 14;
    localparam int total_transfers = 56;
    localparam int reset_cycles    = 16;
    localparam int slack_cycles    = 8;   // Handshake turnaround per transfer

    localparam int budget_cycles = 4 * (power_on_cycles + total_transfers * 2 * e_cycles
        + long_cycles + short_cycles + clear_cycles + total_transfers * slack_cycles);
    localparam int watchdog_ns = (budget_cycles + reset_cycles) * 20;

    localparam logic [39:0] init_cmds = 40'h28_08_01_06_0F;
    localparam logic [79:0] line1     = "COLOR MODE";
    localparam logic [71:0] line2     = "TYPE MODE";

    logic        clk = 1'b0;
    logic        nrst;
    lcd_nibble_t db;
    logic        rs;
    logic        e;
    logic        done;

    logic [4:0] captured[$];  // {rs, db} per enable pulse
    int         pulse_count = 0;
    int         compared = 0;
    int         low_run = 0;
    logic       e_prev = 1'b0;
    event       pulse_seen;

    lcd_text_top #(
        .e_cycles        (e_cycles),
        .power_on_cycles (power_on_cycles),
        .short_cycles    (short_cycles),
        .long_cycles     (long_cycles),
        .clear_cycles    (clear_cycles)
    ) u_lcd_text_top (
        .clk  (clk),
        .nrst (nrst),
        .db   (db),
        .rs   (rs),
        .e    (e),
        .done (done)
    );

    bind lcd_nibble_tx lcd_bus_checker #(.e_cycles(e_cycles)) u_bus_checker (
        .clk (clk), .nrst (nrst), .db (db), .rs (rs), .e (e), .ack (ack)
    );

    always #10 clk = ~clk;

    // {rs, nibble} of transfer n: 4 wake-up nibbles, then two nibbles per byte
    function automatic logic [4:0] expected_nibble(input int n);
        logic [7:0] b;
        logic       is_char;
        int         k;
        if (n < 4) begin
            return {1'b0, (n == 3) ? 4'h2 : 4'h3};
        end
        k       = (n - 4) / 2;
        is_char = 1'b0;
        if (k < 5)       b = init_cmds[8 * (4 - k) +: 8];
        else if (k == 5) b = 8'h80;
        else if (k < 16) begin
            b       = line1[8 * (15 - k) +: 8];
            is_char = 1'b1;
        end else if (k == 16) b = 8'hC0;
        else begin
            b       = line2[8 * (25 - k) +: 8];
            is_char = 1'b1;
        end
        return {is_char, (n % 2 == 0) ? b[7:4] : b[3:0]};
    endfunction

    // Minimum post wait after transfer n, only the slow commands have one
    function automatic int wait_after(input int n);
        case (n)
            0:       return long_cycles;
            1:       return short_cycles;
            9:       return clear_cycles;   // Lower nibble of clear
            default: return 0;
        endcase
    endfunction

    task automatic report_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_nibble(input string name, input lcd_nibble_t got, input lcd_nibble_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_rs(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp);
            report_failure();
        end
    endtask

    // Pin monitor, edges of e found on the falling clock edge where pins are settled
    always @(negedge clk) begin
        if (!nrst) begin
            low_run = 0;
            e_prev  = 1'b0;
        end else begin
            if (e && !e_prev && pulse_count > 0) begin
                if (low_run < e_cycles + wait_after(pulse_count - 1)) begin
                    $display("Enable rose %0d cycles after transfer %0d, too soon",
                             low_run, pulse_count - 1);
                    report_failure();
                end
            end
            if (!e && e_prev) begin
                captured.push_back({rs, db});
                pulse_count = pulse_count + 1;
                -> pulse_seen;
            end
            if (done && pulse_count < total_transfers) begin
                $display("done rose after only %0d enable pulses", pulse_count);
                report_failure();
            end
            low_run = e ? 0 : low_run + 1;
            e_prev  = e;
        end
    end

    // Compare each captured transfer with the reference
    initial begin
        logic [4:0] got;
        logic [4:0] exp;
        forever begin
            @(pulse_seen);
            while (captured.size() > 0) begin
                got = captured.pop_front();
                if (compared >= total_transfers) begin
                    $display("Unexpected enable pulse beyond the end of the script");
                    report_failure();
                end
                exp = expected_nibble(compared);
                check_rs($sformatf("rs (transfer %0d)", compared), got[4], exp[4]);
                check_nibble($sformatf("db (transfer %0d)", compared), got[3:0], exp[3:0]);
                compared = compared + 1;
            end
        end
    end

    initial begin
        nrst = 1'b0;
        repeat (reset_cycles) begin
            @(negedge clk);
            check_level("e", e, 1'b0);
            check_level("done", done, 1'b0);
        end
        nrst = 1'b1;
        // Panel still powering up, bus must stay quiet
        repeat (power_on_cycles) begin
            @(negedge clk);
            check_level("e", e, 1'b0);
            check_level("done", done, 1'b0);
        end
        while (done !== 1'b1) @(negedge clk);
        check_count("pulse_count", pulse_count, total_transfers);
        check_count("compared", compared, total_transfers);
        repeat (200) @(negedge clk);
        check_count("pulse_count", pulse_count, total_transfers);
        check_level("e", e, 1'b0);
        check_level("done", done, 1'b1);
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, done never rose", watchdog_ns);
        report_failure();
    end

endmodule

// ==== verilog/lcd_nibble_tx.sv ====
/*
 * Drives db, rs and e for one nibble per req/ack handshake.
 * Holds off after reset for the power-on delay, then times each enable pulse and wait.
 */
module lcd_nibble_tx #(
    parameter int e_cycles        = 2000,
    parameter int power_on_cycles = 1_500_000,
    parameter int short_cycles    = 10_000,
    parameter int long_cycles     = 410_000,
    parameter int clear_cycles    = 152_000
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 req,
    input  lcd_pkg::lcd_nibble_t nibble,
    input  logic                 rs_in,
    input  lcd_pkg::lcd_wait_e   wait_sel,
    output logic                 ack,
    output lcd_pkg::lcd_nibble_t db,
    output logic                 rs,
    output logic                 e
);
    import lcd_pkg::*;

    localparam logic [2:0] ph_power_up = 3'd0;
    localparam logic [2:0] ph_ready    = 3'd1;
    localparam logic [2:0] ph_e_high   = 3'd2;
    localparam logic [2:0] ph_e_low    = 3'd3;
    localparam logic [2:0] ph_wait     = 3'd4;
    localparam logic [2:0] ph_ack      = 3'd5;

    localparam logic [31:0] e_load  = 32'(e_cycles - 1);
    localparam logic [31:0] po_load = 32'(power_on_cycles - 1);

    logic [2:0]  phase;
    logic [31:0] count;      // Shared by every timed phase
    lcd_wait_e   wait_lat;
    logic [31:0] wait_count;

    always_comb begin
        case (wait_lat)
            wait_short: wait_count = 32'(short_cycles);
            wait_long:  wait_count = 32'(long_cycles);
            wait_clear: wait_count = 32'(clear_cycles);
            default:    wait_count = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            phase <= ph_power_up;
            count <= po_load;
            ack   <= 1'b0;
            db    <= '0;
            rs    <= 1'b0;
            e     <= 1'b0;
        end else begin
            case (phase)
                ph_power_up: begin
                    if (count == 32'd0) phase <= ph_ready;
                    else                count <= count - 32'd1;
                end
                ph_ready: begin
                    if (req) begin
                        db    <= nibble;
                        rs    <= rs_in;
                        e     <= 1'b1;   // High from the next cycle
                        count <= e_load;
                        phase <= ph_e_high;
                    end
                end
                ph_e_high: begin
                    if (count == 32'd0) begin
                        e     <= 1'b0;
                        count <= e_load;
                        phase <= ph_e_low;
                    end else begin
                        count <= count - 32'd1;
                    end
                end
                ph_e_low: begin
                    if (count != 32'd0) begin
                        count <= count - 32'd1;
                    end else if (wait_count == 32'd0) begin
                        ack   <= 1'b1;
                        phase <= ph_ack;
                    end else begin
                        count <= wait_count - 32'd1;
                        phase <= ph_wait;
                    end
                end
                ph_wait: begin
                    if (count == 32'd0) begin
                        ack   <= 1'b1;
                        phase <= ph_ack;
                    end else begin
                        count <= count - 32'd1;
                    end
                end
                ph_ack: begin
                    // Four-phase return to idle
                    if (!req) begin
                        ack   <= 1'b0;
                        phase <= ph_ready;
                    end
                end
                default: phase <= ph_ready;
            endcase
        end
    end

    // Wait selector captured with the nibble
    always_ff @(posedge clk) begin
        if (phase == ph_ready && req) wait_lat <= wait_sel;
    end

endmodule

// ==== verilog/lcd_pkg.sv ====
/*
 * Shared types for the 4-bit character LCD driver.
 * Imported by the script ROM, the sequencer, the nibble transmitter and the top level.
 */
package lcd_pkg;

    // Bus widths
    typedef logic [3:0] lcd_nibble_t;   // Data nibble on db
    typedef logic [7:0] lcd_byte_t;     // Command or character code

    // Wait applied after the final nibble of a transfer
    typedef enum logic [1:0] {
        wait_none  = 2'd0,  // Enable pulse timing only
        wait_short = 2'd1,  // 100 us class
        wait_long  = 2'd2,  // 4.1 ms class
        wait_clear = 2'd3   // 1.52 ms class, clear display
    } lcd_wait_e;

    // Command view of a script word
    typedef struct packed {
        logic      is_char;        // Always 0 here
        logic      single_nibble;  // Wake-up nibble, low four bits sent once
        lcd_wait_e post_wait;
        lcd_byte_t code;
    } lcd_cmd_word_t;

    // Character view of a script word
    typedef struct packed {
        logic      is_char;        // Always 1 here
        logic [2:0] unused;
        lcd_byte_t code;
    } lcd_char_word_t;

    /*
     * One 12-bit script word. The top bit tells which view applies,
     * so the same word is decoded as a command or as a character.
     */
    typedef union packed {
        lcd_cmd_word_t  cmd;
        lcd_char_word_t chr;
    } lcd_step_t;

    // Script length: 4 wake-up, 5 init, 2 addresses, 19 characters
    localparam int script_len = 30;

    typedef logic [4:0] step_idx_t;

endpackage

// ==== verilog/lcd_script_rom.sv ====
/*
 * Constant script for the LCD: wake-up nibbles, init commands, line
 * addresses and text. Pure lookup, the word follows step_idx combinationally.
 */
module lcd_script_rom (
    input  lcd_pkg::step_idx_t step_idx,
    output lcd_pkg::lcd_step_t step
);
    import lcd_pkg::*;

    function automatic lcd_step_t cmd_word(input logic single, input lcd_wait_e post,
                                           input lcd_byte_t code);
        lcd_step_t w;
        w.cmd.is_char       = 1'b0;
        w.cmd.single_nibble = single;
        w.cmd.post_wait     = post;
        w.cmd.code          = code;
        return w;
    endfunction

    function automatic lcd_step_t char_word(input lcd_byte_t code);
        lcd_step_t w;
        w.chr.is_char = 1'b1;
        w.chr.unused  = 3'b000;
        w.chr.code    = code;
        return w;
    endfunction

    always_comb begin
        case (step_idx)
            // 8-bit to 4-bit wake-up, one nibble each
            5'd0:  step = cmd_word(1'b1, wait_long,  8'h03);
            5'd1:  step = cmd_word(1'b1, wait_short, 8'h03);
            5'd2:  step = cmd_word(1'b1, wait_none,  8'h03);
            5'd3:  step = cmd_word(1'b1, wait_none,  8'h02);

            5'd4:  step = cmd_word(1'b0, wait_none,  8'h28); // 4-bit, 2 lines, 5x8
            5'd5:  step = cmd_word(1'b0, wait_none,  8'h08); // Display off
            5'd6:  step = cmd_word(1'b0, wait_clear, 8'h01); // Clear, slow on the panel
            5'd7:  step = cmd_word(1'b0, wait_none,  8'h06); // Increment, no shift
            5'd8:  step = cmd_word(1'b0, wait_none,  8'h0F); // Display, cursor, blink on

            // Line 1: "COLOR MODE"
            5'd9:  step = cmd_word(1'b0, wait_none,  8'h80);
            5'd10: step = char_word(8'h43);  // C
            5'd11: step = char_word(8'h4F);  // O
            5'd12: step = char_word(8'h4C);  // L
            5'd13: step = char_word(8'h4F);  // O
            5'd14: step = char_word(8'h52);  // R
            5'd15: step = char_word(8'h20);  // Space
            5'd16: step = char_word(8'h4D);  // M
            5'd17: step = char_word(8'h4F);  // O
            5'd18: step = char_word(8'h44);  // D
            5'd19: step = char_word(8'h45);  // E

            // Line 2: "TYPE MODE"
            5'd20: step = cmd_word(1'b0, wait_none,  8'hC0);
            5'd21: step = char_word(8'h54);  // T
            5'd22: step = char_word(8'h59);  // Y
            5'd23: step = char_word(8'h50);  // P
            5'd24: step = char_word(8'h45);  // E
            5'd25: step = char_word(8'h20);  // Space
            5'd26: step = char_word(8'h4D);  // M
            5'd27: step = char_word(8'h4F);  // O
            5'd28: step = char_word(8'h44);  // D
            5'd29: step = char_word(8'h45);  // E

            default: step = cmd_word(1'b0, wait_none, 8'h00);
        endcase
    end

endmodule

// ==== verilog/lcd_sequencer.sv ====
/*
 * Walks the script one step at a time and splits each byte into nibbles.
 * Every nibble goes to the transmitter over a four-phase req/ack handshake.
 */
module lcd_sequencer (
    input  logic               clk,
    input  logic               nrst,
    output lcd_pkg::step_idx_t step_idx,
    input  lcd_pkg::lcd_step_t step,
    output logic               req,
    output lcd_pkg::lcd_nibble_t tx_nibble,
    output logic               tx_rs,
    output lcd_pkg::lcd_wait_e tx_wait,
    input  logic               ack,
    output logic               done
);
    import lcd_pkg::*;

    localparam logic [2:0] st_req_upper = 3'd0;  // Also the idle point between steps
    localparam logic [2:0] st_await_ack = 3'd1;
    localparam logic [2:0] st_release   = 3'd2;
    localparam logic [2:0] st_req_lower = 3'd3;
    localparam logic [2:0] st_finished  = 3'd4;

    localparam step_idx_t last_step = step_idx_t'(script_len - 1);

    logic [2:0] state;
    logic       last_nibble;   // Transfer in flight ends the step
    lcd_byte_t  code;
    lcd_wait_e  final_wait;
    logic       single;

    // Decode the current word by its top bit
    always_comb begin
        code = step.cmd.code;  // Same bits in either view
        if (step.cmd.is_char) begin
            final_wait = wait_none;
            single     = 1'b0;
        end else begin
            final_wait = step.cmd.post_wait;
            single     = step.cmd.single_nibble;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= st_req_upper;
            step_idx    <= '0;
            req         <= 1'b0;
            last_nibble <= 1'b0;
            done        <= 1'b0;
        end else begin
            case (state)
                st_req_upper: begin
                    req         <= 1'b1;
                    last_nibble <= single;
                    state       <= st_await_ack;
                end
                st_await_ack: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= st_release;
                    end
                end
                st_release: begin
                    // Next request only once ack has dropped
                    if (!ack) begin
                        if (!last_nibble) begin
                            state <= st_req_lower;
                        end else if (step_idx == last_step) begin
                            done  <= 1'b1;
                            state <= st_finished;
                        end else begin
                            step_idx <= step_idx + 5'd1;
                            state    <= st_req_upper;
                        end
                    end
                end
                st_req_lower: begin
                    req         <= 1'b1;
                    last_nibble <= 1'b1;
                    state       <= st_await_ack;
                end
                st_finished: state <= st_finished;
                default:     state <= st_req_upper;
            endcase
        end
    end

    // Payload set together with req and held until the next request
    always_ff @(posedge clk) begin
        if (state == st_req_upper) begin
            tx_nibble <= single ? code[3:0] : code[7:4];
            tx_rs     <= step.chr.is_char;
            tx_wait   <= single ? final_wait : wait_none;  // Wait only after the last nibble
        end else if (state == st_req_lower) begin
            tx_nibble <= code[3:0];
            tx_rs     <= step.chr.is_char;
            tx_wait   <= final_wait;
        end
    end

endmodule

// ==== verilog/lcd_text_top.sv ====
/*
 * Two-line text display on an HD44780-style LCD over its 4-bit bus.
 * Set the timing parameters for the clock rate; done rises when the text is written.
 */
module lcd_text_top #(
    parameter int e_cycles        = 2000,
    parameter int power_on_cycles = 1_500_000,
    parameter int short_cycles    = 10_000,
    parameter int long_cycles     = 410_000,
    parameter int clear_cycles    = 152_000
) (
    input  logic                 clk,
    input  logic                 nrst,
    output lcd_pkg::lcd_nibble_t db,
    output logic                 rs,
    output logic                 e,
    output logic                 done
);
    import lcd_pkg::*;

    step_idx_t   step_idx;
    lcd_step_t   step;
    logic        req;
    logic        ack;
    lcd_nibble_t tx_nibble;
    logic        tx_rs;
    lcd_wait_e   tx_wait;

    lcd_script_rom u_rom (
        .step_idx (step_idx),
        .step     (step)
    );

    lcd_sequencer u_seq (
        .clk       (clk),
        .nrst      (nrst),
        .step_idx  (step_idx),
        .step      (step),
        .req       (req),
        .tx_nibble (tx_nibble),
        .tx_rs     (tx_rs),
        .tx_wait   (tx_wait),
        .ack       (ack),
        .done      (done)
    );

    lcd_nibble_tx #(
        .e_cycles        (e_cycles),
        .power_on_cycles (power_on_cycles),
        .short_cycles    (short_cycles),
        .long_cycles     (long_cycles),
        .clear_cycles    (clear_cycles)
    ) u_tx (
        .clk      (clk),
        .nrst     (nrst),
        .req      (req),
        .nibble   (tx_nibble),
        .rs_in    (tx_rs),
        .wait_sel (tx_wait),
        .ack      (ack),
        .db       (db),
        .rs       (rs),
        .e        (e)
    );

endmodule
